// File: src.f
rtl/isaPkg.sv
rtl/busPkg.sv
rtl/memPort.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/riscvTop.sv
bench/coreChecks_sva.sv
bench/tbTop.sv

// File: run.sh
#!/bin/sh
# Builds with Verilator, runs the testbench and checks its verdict in the output
verilator --binary --assert --top-module tbTop -f src.f -o simv \
	&& ./obj_dir/simv +verilator+error+limit+100 | tee /dev/stderr \
	| grep -F "** PASS **" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: bench/tbTop.sv
// Random ack delays of 0 to 4 cycles; program and data memories hold 64 words each
module tbTop;
	timeunit 1ns;
	timeprecision 100ps;
	import isaPkg::*;
	import busPkg::*;

	localparam int progLen    = 53;
	localparam int doneWord   = 63; // Final store lands here
	localparam int watchdogNs = progLen * (2 * 4 + 6) * 20 * 3;

	logic    clk       = 1'b0;
	logic    rst_n     = 1'b0;
	logic    imemAck   = 1'b0;
	wordT    imemRdata = '0;
	logic    dmemAck   = 1'b0;
	wordT    dmemRdata = '0;
	logic    imemReq, dmemReq, dmemWe;
	memAddrT imemAddr, dmemAddr;
	wordT    dmemWdata;

	wordT prog [64];
	wordT dataMem [64];
	wordT expectTab [int];
	string nameTab [int];
	logic seenTab [int];
	int   imemDelay, dmemDelay;
	int   passes = 0;
	int   failures = 0;
	logic doneSeen = 1'b0;
	logic verdictShown = 1'b0;

	riscvTop dut (.*);

	bind riscvTop coreChecks_sva checks (.*);

	always #10 clk = ~clk;

	// ========================================
	// Instruction encoders
	// ========================================
	function automatic wordT rTypeWord(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opReg};
	endfunction

	function automatic wordT iTypeWord(input logic [6:0] op, input logic [2:0] f3,
		input int rd, input int rs1, input int imm);
		return {12'(imm), 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic wordT storeWord(input int rs2, input int rs1, input int imm);
		logic [11:0] s;
		s = 12'(imm);
		return {s[11:5], 5'(rs2), 5'(rs1), 3'b010, s[4:0], opStore};
	endfunction

	function automatic wordT branchWord(input logic [2:0] f3, input int rs1, input int rs2,
		input int off);
		logic [12:0] b;
		b = 13'(off);
		return {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], opBranch};
	endfunction

	function automatic wordT jalWord(input int rd, input int off);
		logic [20:0] j;
		j = 21'(off);
		return {j[20], j[10:1], j[11], j[19:12], 5'(rd), opJal};
	endfunction

	function automatic wordT fillWord(input int a);
		return 32'h5A5A_0000 ^ (a * 32'h0001_0101);
	endfunction

	task automatic expectStore(input int byteAddr, input wordT value, input string name);
		expectTab[byteAddr / 4] = value;
		nameTab[byteAddr / 4]   = name;
	endtask

	task automatic checkStore(input memAddrT addr, input wordT data);
		int key;
		key = int'(addr);
		if (!expectTab.exists(key)) begin
			$display("Store of %h went to unexpected word address %0d", data, key);
			failures++;
		end else if (data === expectTab[key]) begin
			$display("ok   %s", nameTab[key]);
			passes++;
		end else begin
			$display("FAIL %s expected %h actual %h", nameTab[key], expectTab[key], data);
			failures++;
		end
		seenTab[key] = 1'b1;
		if (key == doneWord)
			doneSeen = 1'b1;
	endtask

	// ========================================
	// Memory responders
	// ========================================
	always @(posedge clk) begin
		if (!rst_n) begin
			imemAck   <= 1'b0;
			imemDelay <= $urandom_range(4, 0);
		end else if (imemReq && !imemAck) begin
			if (imemDelay == 0) begin
				imemAck   <= 1'b1;
				imemRdata <= (imemAddr < 30'd64) ? prog[imemAddr[5:0]] : nopInst;
				imemDelay <= $urandom_range(4, 0);
			end else begin
				imemDelay <= imemDelay - 1;
			end
		end else if (!imemReq && imemAck) begin
			imemAck <= 1'b0; // Release phase
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			dmemAck   <= 1'b0;
			dmemDelay <= $urandom_range(4, 0);
		end else if (dmemReq && !dmemAck) begin
			if (dmemDelay == 0) begin
				dmemAck   <= 1'b1;
				dmemRdata <= dataMem[dmemAddr[5:0]];
				if (dmemWe) begin
					dataMem[dmemAddr[5:0]] <= dmemWdata;
					checkStore(dmemAddr, dmemWdata); // Write completes on ack
				end
				dmemDelay <= $urandom_range(4, 0);
			end else begin
				dmemDelay <= dmemDelay - 1;
			end
		end else if (!dmemReq && dmemAck) begin
			dmemAck <= 1'b0;
		end
	end

	// ========================================
	// Program, expectations and run
	// ========================================
	initial begin
		void'($urandom(55));
		for (int i = 0; i < 64; i++) begin
			prog[i]    = nopInst;
			dataMem[i] = fillWord(i);
		end
		// ALU group on operands 100 and -7
		prog[0]  = iTypeWord(opImm, 3'b000, 1, 0, 100);
		prog[1]  = iTypeWord(opImm, 3'b000, 2, 0, -7);
		prog[2]  = rTypeWord(7'h00, 3'b000, 3, 1, 2);
		prog[3]  = storeWord(3, 0, 64);
		prog[4]  = rTypeWord(7'h20, 3'b000, 4, 1, 2); // sub
		prog[5]  = storeWord(4, 0, 68);
		prog[6]  = rTypeWord(7'h00, 3'b001, 5, 1, 2);
		prog[7]  = storeWord(5, 0, 72);
		prog[8]  = rTypeWord(7'h00, 3'b010, 6, 2, 1); // slt x6, x2, x1
		prog[9]  = storeWord(6, 0, 76);
		prog[10] = rTypeWord(7'h00, 3'b100, 7, 1, 2);
		prog[11] = storeWord(7, 0, 80);
		prog[12] = rTypeWord(7'h00, 3'b101, 8, 2, 1);
		prog[13] = storeWord(8, 0, 84);
		prog[14] = rTypeWord(7'h20, 3'b101, 9, 2, 1); // sra
		prog[15] = storeWord(9, 0, 88);
		prog[16] = rTypeWord(7'h00, 3'b110, 10, 1, 2);
		prog[17] = storeWord(10, 0, 92);
		prog[18] = rTypeWord(7'h00, 3'b111, 11, 1, 2);
		prog[19] = storeWord(11, 0, 96);
		// Dependent chain and a write to x0
		prog[20] = iTypeWord(opImm, 3'b000, 12, 0, 5);
		prog[21] = rTypeWord(7'h00, 3'b000, 13, 12, 12);
		prog[22] = rTypeWord(7'h00, 3'b000, 14, 13, 12);
		prog[23] = rTypeWord(7'h00, 3'b000, 0, 14, 14);
		prog[24] = rTypeWord(7'h00, 3'b000, 15, 0, 14);
		prog[25] = storeWord(15, 0, 100);
		prog[26] = storeWord(0, 0, 104);
		// Load-use with add and beq
		prog[27] = iTypeWord(opLoad, 3'b010, 16, 0, 32);
		prog[28] = rTypeWord(7'h00, 3'b000, 17, 16, 1);
		prog[29] = storeWord(17, 0, 108);
		prog[30] = iTypeWord(opLoad, 3'b010, 18, 0, 32);
		prog[31] = branchWord(3'b000, 18, 16, 8);
		prog[32] = storeWord(0, 0, 160); // Poison
		prog[33] = storeWord(18, 0, 112);
		// Branches taken and not taken
		prog[34] = iTypeWord(opImm, 3'b000, 19, 0, 3);
		prog[35] = branchWord(3'b001, 19, 0, 8);
		prog[36] = storeWord(0, 0, 160);
		prog[37] = branchWord(3'b000, 19, 0, 8);
		prog[38] = iTypeWord(opImm, 3'b000, 20, 19, 1);
		prog[39] = branchWord(3'b001, 20, 20, 8);
		prog[40] = iTypeWord(opImm, 3'b000, 20, 20, 1);
		prog[41] = storeWord(20, 0, 116);
		// Jumps
		prog[42] = jalWord(21, 8);
		prog[43] = storeWord(0, 0, 160);
		prog[44] = storeWord(21, 0, 120);
		prog[45] = iTypeWord(opImm, 3'b000, 22, 0, 196);
		prog[46] = iTypeWord(opJalr, 3'b000, 23, 22, 0); // Target from a fresh x22
		prog[47] = storeWord(0, 0, 160);
		prog[48] = storeWord(0, 0, 160);
		prog[49] = storeWord(23, 0, 124);
		prog[50] = iTypeWord(opImm, 3'b000, 24, 0, 1);
		prog[51] = storeWord(24, 0, 252);
		prog[52] = jalWord(0, 0);

		expectStore(64, 32'h0000_005D, "add");
		expectStore(68, 32'h0000_006B, "sub");
		expectStore(72, 32'hC800_0000, "sll");
		expectStore(76, 32'h0000_0001, "slt");
		expectStore(80, 32'hFFFF_FF9D, "xor");
		expectStore(84, 32'h0FFF_FFFF, "srl");
		expectStore(88, 32'hFFFF_FFFF, "sra");
		expectStore(92, 32'hFFFF_FFFD, "or");
		expectStore(96, 32'h0000_0060, "and");
		expectStore(100, 32'd15, "forward chain");
		expectStore(104, 32'd0, "x0 stays zero");
		expectStore(108, fillWord(8) + 32'd100, "load use add");
		expectStore(112, fillWord(8), "load use beq");
		expectStore(116, 32'd5, "branches");
		expectStore(120, 32'd172, "jal link");
		expectStore(124, 32'd188, "jalr link");
		expectStore(252, 32'd1, "final store");

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		while (!doneSeen)
			@(posedge clk);
		while (dmemReq || dmemAck)
			@(posedge clk); // Last handshake completes

		foreach (expectTab[key]) begin
			if (!seenTab.exists(key)) begin
				$display("Test %s never stored its result", nameTab[key]);
				failures++;
			end
		end
		$display("Summary: %0d passed, %0d failed, %0d assertion failures",
			passes, failures, dut.checks.failCount);
		verdictShown = 1'b1;
		if (failures == 0 && dut.checks.failCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdogNs);
		$display("Timeout: the program never reached its final store");
		verdictShown = 1'b1;
		$display("** FAIL **");
		$finish;
	end

	final begin
		if (!verdictShown)
			$display("** FAIL **"); // Run stopped before the summary
	end

endmodule

// File: bench/coreChecks_sva.sv
// Bound to riscvTop; the poison word 40 matches the program image of the testbench
module coreChecks_sva (
	input logic            clk,
	input logic            rst_n,
	input logic            imemReq,
	input busPkg::memAddrT imemAddr,
	input logic            imemAck,
	input logic            dmemReq,
	input logic            dmemWe,
	input busPkg::memAddrT dmemAddr,
	input isaPkg::wordT    dmemWdata,
	input logic            dmemAck
);
	timeunit 1ns;
	timeprecision 100ps;
	import busPkg::*;

	localparam memAddrT poisonWord = 30'd40; // Byte address 160

	int unsigned failCount = 0;

	// Quiet during reset and one cycle past it
	resetQuiet: assert property (@(posedge clk) $past(!rst_n) |-> !imemReq && !dmemReq && !dmemWe)
		else begin
			failCount++;
			$error("memory request raised during reset or in the first cycle after it");
		end

	// ========================================
	// Four-phase handshake
	// ========================================
	imemHold: assert property (@(posedge clk) disable iff (!rst_n)
		imemReq && !imemAck |=> imemReq && $stable(imemAddr))
		else begin
			failCount++;
			$error("imem request dropped or changed before ack");
		end

	dmemHold: assert property (@(posedge clk) disable iff (!rst_n)
		dmemReq && !dmemAck |=> dmemReq && $stable(dmemAddr) && $stable(dmemWe)
			&& $stable(dmemWdata))
		else begin
			failCount++;
			$error("dmem request dropped or changed before ack");
		end

	imemNoRise: assert property (@(posedge clk) disable iff (!rst_n)
		!imemReq && imemAck |=> !imemReq)
		else begin
			failCount++;
			$error("imem request rose while ack was still high");
		end

	dmemNoRise: assert property (@(posedge clk) disable iff (!rst_n)
		!dmemReq && dmemAck |=> !dmemReq)
		else begin
			failCount++;
			$error("dmem request rose while ack was still high");
		end

	// Skipped instructions never reach memory
	noPoison: assert property (@(posedge clk) disable iff (!rst_n)
		dmemReq && dmemWe |-> dmemAddr != poisonWord)
		else begin
			failCount++;
			$error("a skipped instruction stored to the poison address");
		end

endmodule

// File: rtl/riscvTop.sv
// Unsupported opcodes run as no-ops; both memories are word ports on a four-phase req/ack
module riscvTop (
	input  logic            clk,
	input  logic            rst_n,
	output logic            imemReq,
	output busPkg::memAddrT imemAddr,
	input  logic            imemAck,
	input  isaPkg::wordT    imemRdata,
	output logic            dmemReq,
	output logic            dmemWe,
	output busPkg::memAddrT dmemAddr,
	output isaPkg::wordT    dmemWdata,
	input  logic            dmemAck,
	input  isaPkg::wordT    dmemRdata
);
	import isaPkg::*;
	import busPkg::*;

	wordT    pc, fetchWord, idPc, idInst, redirectPc;
	logic    stall, hazardStall, redirect, imemBusy, dmemBusy;
	regAddrT exRs1, exRs2, exRd, meRd, wbRd;
	wordT    exA, exB, exImm, exPcPlus4;
	wordT    meResult, meStoreData, loadWord, wbData;
	aluOpT   exAluOp;
	logic    exAluSrc, exMemRead, exMemWrite, exMemToReg, exWrEn, exIsJump;
	logic    meWrEn, meIsLoad, meMemWrite, meMemToReg, wbWrEn;
	memAddrT pcWord;
	memAddrT dataWord;

	assign stall    = imemBusy || dmemBusy; // Either side still waiting
	assign pcWord   = pc[31:2];
	assign dataWord = meResult[31:2];

	// ========================================
	// Pipeline stages
	// ========================================
	fetchStage   fetch   (.*);
	decodeStage  decode  (.*);
	executeStage execute (.*);
	memWbStage   memWb   (.*);

	// ========================================
	// Memory sides
	// ========================================
	memPort imemPort (
		.clk      (clk),
		.rst_n    (rst_n),
		.need     (1'b1), // Fetch never pauses
		.write    (1'b0),
		.addr     (pcWord),
		.wdata    ('0),
		.advance  (!stall),
		.rdata    (fetchWord),
		.busy     (imemBusy),
		.req      (imemReq),
		.we       (),
		.memAddr  (imemAddr),
		.memWdata (),
		.ack      (imemAck),
		.memRdata (imemRdata)
	);

	memPort dmemPort (
		.clk      (clk),
		.rst_n    (rst_n),
		.need     (meIsLoad || meMemWrite),
		.write    (meMemWrite),
		.addr     (dataWord),
		.wdata    (meStoreData),
		.advance  (!stall),
		.rdata    (loadWord),
		.busy     (dmemBusy),
		.req      (dmemReq),
		.we       (dmemWe),
		.memAddr  (dmemAddr),
		.memWdata (dmemWdata),
		.ack      (dmemAck),
		.memRdata (dmemRdata)
	);

endmodule

// File: rtl/memWbStage.sv
// The load word must be valid whenever the pipeline advances with a load in the memory stage
module memWbStage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  isaPkg::regAddrT meRd,
	input  logic            meWrEn,
	input  logic            meMemToReg,
	input  isaPkg::wordT    meResult,
	input  isaPkg::wordT    loadWord,
	output isaPkg::regAddrT wbRd,
	output logic            wbWrEn,
	output isaPkg::wordT    wbData
);
	import isaPkg::*;

	logic wbMemToReg;
	wordT wbResult;
	wordT wbLoad;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wbWrEn     <= 1'b0;
			wbMemToReg <= 1'b0;
		end else if (!stall) begin
			wbWrEn     <= meWrEn;
			wbMemToReg <= meMemToReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			wbRd     <= meRd;
			wbResult <= meResult;
			wbLoad   <= loadWord;
		end
	end

	assign wbData = wbMemToReg ? wbLoad : wbResult;

endmodule

// File: rtl/executeStage.sv
// Relies on decode stalling load-use pairs; meResult of a load is its address, not its data
module executeStage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  isaPkg::regAddrT exRs1,
	input  isaPkg::regAddrT exRs2,
	input  isaPkg::regAddrT exRd,
	input  isaPkg::wordT    exA,
	input  isaPkg::wordT    exB,
	input  isaPkg::wordT    exImm,
	input  isaPkg::wordT    exPcPlus4,
	input  isaPkg::aluOpT   exAluOp,
	input  logic            exAluSrc,
	input  logic            exMemRead,
	input  logic            exMemWrite,
	input  logic            exMemToReg,
	input  logic            exWrEn,
	input  logic            exIsJump,
	input  isaPkg::regAddrT wbRd,
	input  logic            wbWrEn,
	input  isaPkg::wordT    wbData,
	output isaPkg::regAddrT meRd,
	output logic            meWrEn,
	output logic            meIsLoad,
	output logic            meMemWrite,
	output logic            meMemToReg,
	output isaPkg::wordT    meResult,
	output isaPkg::wordT    meStoreData
);
	import isaPkg::*;

	wordT opA, opB, aluIn2, aluOut;

	// Memory stage wins over write-back when forwarding
	assign opA = (exRs1 != '0 && meWrEn && meRd == exRs1) ? meResult :
		(exRs1 != '0 && wbWrEn && wbRd == exRs1) ? wbData : exA;
	assign opB = (exRs2 != '0 && meWrEn && meRd == exRs2) ? meResult :
		(exRs2 != '0 && wbWrEn && wbRd == exRs2) ? wbData : exB;
	assign aluIn2 = exAluSrc ? exImm : opB;

	always_comb begin
		case (exAluOp)
			aluAdd:  aluOut = opA + aluIn2;
			aluSub:  aluOut = opA - aluIn2;
			aluSll:  aluOut = opA << aluIn2[4:0];
			aluSlt:  aluOut = {31'b0, $signed(opA) < $signed(aluIn2)};
			aluXor:  aluOut = opA ^ aluIn2;
			aluSrl:  aluOut = opA >> aluIn2[4:0];
			aluSra:  aluOut = $signed(opA) >>> aluIn2[4:0];
			aluOr:   aluOut = opA | aluIn2;
			aluAnd:  aluOut = opA & aluIn2;
			default: aluOut = '0;
		endcase
	end

	// ========================================
	// EX/MEM register
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			meWrEn     <= 1'b0;
			meIsLoad   <= 1'b0;
			meMemWrite <= 1'b0;
			meMemToReg <= 1'b0;
		end else if (!stall) begin
			meWrEn     <= exWrEn;
			meIsLoad   <= exMemRead;
			meMemWrite <= exMemWrite;
			meMemToReg <= exMemToReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			meRd        <= exRd;
			meResult    <= exIsJump ? exPcPlus4 : aluOut; // Link value forwards like any result
			meStoreData <= opB;
		end
	end

endmodule

// File: rtl/decodeStage.sv
// Branches resolve here, predicted not-taken; only beq and bne of the branch group are decoded
module decodeStage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  isaPkg::wordT    idPc,
	input  isaPkg::wordT    idInst,
	input  isaPkg::regAddrT meRd,
	input  logic            meWrEn,
	input  logic            meIsLoad,
	input  isaPkg::wordT    meResult,
	input  isaPkg::regAddrT wbRd,
	input  logic            wbWrEn,
	input  isaPkg::wordT    wbData,
	output logic            redirect,
	output logic            hazardStall,
	output isaPkg::wordT    redirectPc,
	output isaPkg::regAddrT exRs1,
	output isaPkg::regAddrT exRs2,
	output isaPkg::regAddrT exRd,
	output isaPkg::wordT    exA,
	output isaPkg::wordT    exB,
	output isaPkg::wordT    exImm,
	output isaPkg::wordT    exPcPlus4,
	output isaPkg::aluOpT   exAluOp,
	output logic            exAluSrc,
	output logic            exMemRead,
	output logic            exMemWrite,
	output logic            exMemToReg,
	output logic            exWrEn,
	output logic            exIsJump
);
	import isaPkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	regAddrT    rs1, rs2, rd;
	wordT       rf1, rf2, src1, src2;
	wordT       immI, immShift, immS, immB, immJ, imm;
	logic       isReg, isImm, isLoad, isStore, isBranch, isJal, isJalr;
	logic       wrEn, usesRs1, usesRs2, taken;
	logic       loadUse, exProducer, meLoad;
	aluOpT      aluOp;

	assign opcode = idInst[6:0];
	assign funct3 = idInst[14:12];
	assign rs1    = idInst[19:15];
	assign rs2    = idInst[24:20];
	assign rd     = idInst[11:7];

	// ========================================
	// Control and ALU decode
	// ========================================
	assign isReg    = (opcode == opReg);
	assign isImm    = (opcode == opImm);
	assign isLoad   = (opcode == opLoad) && (funct3 == 3'b010);
	assign isStore  = (opcode == opStore) && (funct3 == 3'b010);
	assign isBranch = (opcode == opBranch) && (funct3[2:1] == 2'b00); // beq, bne
	assign isJal    = (opcode == opJal);
	assign isJalr   = (opcode == opJalr);
	assign wrEn     = isReg || isImm || isLoad || isJal || isJalr;
	assign usesRs1  = isReg || isImm || isLoad || isStore || isBranch || isJalr;
	assign usesRs2  = isReg || isStore || isBranch;

	always_comb begin
		if (isReg || (isImm && funct3 == 3'b101))
			aluOp = aluOpT'({idInst[30], funct3}); // sub and sra carry bit 30
		else if (isImm)
			aluOp = aluOpT'({1'b0, funct3});
		else
			aluOp = aluAdd; // Address for lw and sw
	end

	assign immI     = {{20{idInst[31]}}, idInst[31:20]};
	assign immShift = {27'b0, idInst[24:20]};
	assign immS     = {{20{idInst[31]}}, idInst[31:25], idInst[11:7]};
	assign immB     = {{20{idInst[31]}}, idInst[7], idInst[30:25], idInst[11:8], 1'b0};
	assign immJ     = {{12{idInst[31]}}, idInst[19:12], idInst[20], idInst[30:21], 1'b0};
	assign imm      = isStore ? immS : (isImm && funct3[1:0] == 2'b01) ? immShift : immI;

	regFile rf (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1     (rs1),
		.rs2     (rs2),
		.rd      (wbRd),
		.wrEn    (wbWrEn),
		.wrData  (wbData),
		.rs1Data (rf1),
		.rs2Data (rf2)
	);

	// ========================================
	// Branch resolution
	// ========================================
	// Memory stage has priority over write-back
	// A load in the memory stage is covered by meLoad
	assign src1 = (rs1 != '0 && meWrEn && meRd == rs1) ? meResult :
		(rs1 != '0 && wbWrEn && wbRd == rs1) ? wbData : rf1;
	assign src2 = (rs2 != '0 && meWrEn && meRd == rs2) ? meResult :
		(rs2 != '0 && wbWrEn && wbRd == rs2) ? wbData : rf2;

	assign taken      = isJal || isJalr || (isBranch && ((src1 == src2) != funct3[0]));
	assign redirect   = taken && !hazardStall;
	assign redirectPc = isJalr ? ((src1 + immI) & ~32'd1) :
		isJal ? (idPc + immJ) : (idPc + immB);

	// Hazards
	assign loadUse    = exMemRead && exRd != '0 &&
		((usesRs1 && exRd == rs1) || (usesRs2 && exRd == rs2));
	assign exProducer = (isBranch || isJalr) && exWrEn && exRd != '0 &&
		(exRd == rs1 || (isBranch && exRd == rs2));
	assign meLoad     = (isBranch || isJalr) && meIsLoad && meRd != '0 &&
		(meRd == rs1 || (isBranch && meRd == rs2));
	assign hazardStall = loadUse || exProducer || meLoad;

	// ========================================
	// ID/EX register
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exWrEn     <= 1'b0;
			exIsJump   <= 1'b0;
		end else if (!stall) begin
			// A hazard leaves a bubble behind
			exMemRead  <= isLoad && !hazardStall;
			exMemWrite <= isStore && !hazardStall;
			exMemToReg <= isLoad && !hazardStall;
			exWrEn     <= wrEn && !hazardStall;
			exIsJump   <= (isJal || isJalr) && !hazardStall;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			exRs1     <= rs1;
			exRs2     <= rs2;
			exRd      <= rd;
			exA       <= rf1;
			exB       <= rf2;
			exImm     <= imm;
			exPcPlus4 <= idPc + 32'd4;
			exAluOp   <= aluOp;
			exAluSrc  <= !isReg;
		end
	end

endmodule

// File: rtl/fetchStage.sv
// PC starts at 0; a redirect takes effect on the first cycle without any stall
module fetchStage (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         stall,
	input  logic         hazardStall,
	input  logic         redirect,
	input  isaPkg::wordT redirectPc,
	input  isaPkg::wordT fetchWord,
	output isaPkg::wordT pc,
	output isaPkg::wordT idPc,
	output isaPkg::wordT idInst
);
	import isaPkg::*;

	// PC and IF/ID move together
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc     <= '0;
			idPc   <= '0;
			idInst <= nopInst;
		end else if (!stall && !hazardStall) begin
			if (redirect) begin
				pc     <= redirectPc;
				idInst <= nopInst; // Wrong-path word dropped
			end else begin
				pc     <= pc + 32'd4;
				idInst <= fetchWord;
			end
			idPc <= pc;
		end
	end

endmodule

// File: rtl/regFile.sv
// Combinational reads; writes to x0 are dropped and a same-cycle write is bypassed to reads
module regFile (
	input  logic            clk,
	input  logic            rst_n,
	input  isaPkg::regAddrT rs1,
	input  isaPkg::regAddrT rs2,
	input  isaPkg::regAddrT rd,
	input  logic            wrEn,
	input  isaPkg::wordT    wrData,
	output isaPkg::wordT    rs1Data,
	output isaPkg::wordT    rs2Data
);
	import isaPkg::*;

	wordT regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && rd != '0) begin
			regs[rd] <= wrData;
		end
	end

	assign rs1Data = (rs1 == '0) ? '0 : (wrEn && rd == rs1) ? wrData : regs[rs1];
	assign rs2Data = (rs2 == '0) ? '0 : (wrEn && rd == rs2) ? wrData : regs[rs2];

endmodule

// File: rtl/memPort.sv
// One access at a time; the memory must hold ack until req falls and then drop it
module memPort (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            need,
	input  logic            write,
	input  busPkg::memAddrT addr,
	input  isaPkg::wordT    wdata,
	input  logic            advance,
	output isaPkg::wordT    rdata,
	output logic            busy,
	output logic            req,
	output logic            we,
	output busPkg::memAddrT memAddr,
	output isaPkg::wordT    memWdata,
	input  logic            ack,
	input  isaPkg::wordT    memRdata
);
	import isaPkg::*;
	import busPkg::*;

	memStateT state;
	logic     weHeld;

	// Four-phase sequence
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= memIdle;
		end else begin
			case (state)
				memIdle:    if (need && !ack) state <= memRequest;
				memRequest: if (ack) state <= memRelease;
				memRelease: if (!ack) state <= memHold;
				memHold:    if (advance) state <= memIdle;
				default:    state <= memIdle;
			endcase
		end
	end

	// Request fields frozen for the whole handshake
	always_ff @(posedge clk) begin
		if (state == memIdle && need) begin
			memAddr  <= addr;
			memWdata <= wdata;
			weHeld   <= write;
		end
		if (state == memRequest && ack)
			rdata <= memRdata; // Read word captured on ack
	end

	assign req  = (state == memRequest);
	assign we   = req && weHeld;
	assign busy = need && (state != memHold);

endmodule

// File: rtl/busPkg.sv
// Word addressing only; the two byte-offset bits never leave the core
package busPkg;

	import isaPkg::*;

	typedef logic [xlen-3:0] memAddrT; // Byte address bits 31 to 2

	typedef enum logic [1:0] {
		memIdle,
		memRequest,
		memRelease, // Req low, ack not yet dropped
		memHold     // Word kept until the pipeline moves
	} memStateT;

endpackage

// File: rtl/isaPkg.sv
// RV32I subset only: no compressed, CSR, byte or halfword access; memory words in core order
package isaPkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] wordT; // Data or instruction word
	typedef logic [4:0]      regAddrT;

	// Low three bits follow funct3, bit 3 marks sub and sra
	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSll = 4'b0001,
		aluSlt = 4'b0010,
		aluXor = 4'b0100,
		aluSrl = 4'b0101,
		aluOr  = 4'b0110,
		aluAnd = 4'b0111,
		aluSub = 4'b1000,
		aluSra = 4'b1101
	} aluOpT;

	// ========================================
	// Major opcodes
	// ========================================
	localparam logic [6:0] opReg    = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;

	localparam wordT nopInst = 32'h0000_0013; // addi x0, x0, 0

endpackage
